// File: verilog.f
src/rt_pkg.sv
src/edge_setup.sv
src/det3_unit.sv
src/fip_div_sat.sv
src/hit_test.sv
src/tri_intersect.sv
src/nearest_hit_ctrl.sv
src/ray_tri_batch.sv
tb/ray_tri_batch_chk.sv
tb/tb_ray_tri_batch.sv

// File: tb/tb_ray_tri_batch.sv
// testbench for the ray-triangle batch tester with directed and random batches against a model
`timescale 1ns/1ps

module tb_ray_tri_batch;
    import rt_pkg::*;

    // hits need t of at least one half
    localparam fip_t MIN_T   = 32'sh0000_8000;
    localparam int   N_RAND  = 12;
    localparam int   N_EXTRA = 2;

    typedef struct packed {
        logic hit;
        fip_t t;
    } isect_t;

    typedef struct packed {
        logic     hit;
        fip_t     t;
        tri_idx_t idx;
    } batch_res_t;

    logic     clk;
    logic     i_rstn;
    logic     i_start;
    tri_idx_t i_tri_cnt;
    ray_t     i_ray;
    tri_t     i_tri;
    logic     i_tri_valid;
    logic     o_hit;
    fip_t     o_t;
    tri_idx_t o_tri_index;
    logic     o_done;

    // expected nearest result per batch in arrival order
    batch_res_t exp_q[$];
    batch_res_t best;
    tri_idx_t   next_idx;
    int         mismatch_cnt = 0;
    int         other_cnt    = 0;
    int         cycle_cnt    = 0;
    int         cycle_budget = 0;

    ray_tri_batch #(.MIN_T(MIN_T)) i_ray_tri_batch (
        .clk(clk),
        .i_rstn(i_rstn),
        .i_start(i_start),
        .i_tri_cnt(i_tri_cnt),
        .i_ray(i_ray),
        .i_tri(i_tri),
        .i_tri_valid(i_tri_valid),
        .o_hit(o_hit),
        .o_t(o_t),
        .o_tri_index(o_tri_index),
        .o_done(o_done)
    );

    initial begin : clk_gen
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    // value given in quarters
    function automatic fip_t qtr(input int q);
        return fip_t'(q * 16384);
    endfunction

    function automatic vec3_t v3(input int x, input int y, input int z);
        return '{qtr(x), qtr(y), qtr(z)};
    endfunction

    function automatic vec3_t vsub(input vec3_t p, input vec3_t q);
        return '{p.x - q.x, p.y - q.y, p.z - q.z};
    endfunction

    // product rescaled and wrapped to 32 bits
    function automatic fip_t fmul_ref(input fip_t a, input fip_t b);
        longint p;
        p = longint'(a) * longint'(b);
        return fip_t'(p >>> FRAC_BITS);
    endfunction

    // expansion along the x components
    function automatic fip_t det_ref(input vec3_t c0, input vec3_t c1, input vec3_t c2);
        fip_t k0;
        fip_t k1;
        fip_t k2;
        k0 = fmul_ref(c1.y, c2.z) - fmul_ref(c2.y, c1.z);
        k1 = fmul_ref(c0.y, c2.z) - fmul_ref(c2.y, c0.z);
        k2 = fmul_ref(c0.y, c1.z) - fmul_ref(c1.y, c0.z);
        return fmul_ref(c0.x, k0) - fmul_ref(c1.x, k1) + fmul_ref(c2.x, k2);
    endfunction

    function automatic fip_t div_ref(input fip_t x, input fip_t y);
        longint q;
        if (y == 0) begin
            return (x < 0) ? FIP_MIN : FIP_MAX;
        end
        q = (longint'(x) <<< FRAC_BITS) / longint'(y);
        if (q > FIP_MAX) begin
            return FIP_MAX;
        end
        if (q < FIP_MIN) begin
            return FIP_MIN;
        end
        return fip_t'(q);
    endfunction

    // Cramer solve for a, b and t then the hit conditions
    function automatic isect_t ref_intersect(input tri_t tr, input ray_t ry);
        vec3_t  e;
        vec3_t  t1;
        vec3_t  t2;
        vec3_t  nd;
        fip_t   coef;
        fip_t   a;
        fip_t   b;
        longint ab;
        isect_t r;
        e    = vsub(ry.org, tr.v0);
        t1   = vsub(tr.v1, tr.v0);
        t2   = vsub(tr.v2, tr.v0);
        nd   = vsub('0, ry.dir);
        coef = det_ref(t1, t2, nd);
        a    = div_ref(det_ref(e, t2, nd), coef);
        b    = div_ref(det_ref(t1, e, nd), coef);
        r.t  = div_ref(det_ref(t1, t2, e), coef);
        ab   = longint'(a) + longint'(b);
        if (ab > FIP_MAX) begin
            ab = FIP_MAX;
        end else if (ab < FIP_MIN) begin
            ab = FIP_MIN;
        end
        r.hit = (coef != 0) && (a >= 0) && (b >= 0) && (ab <= FIP_ONE) && (r.t >= MIN_T);
        return r;
    endfunction

    // multiples of 0.5 within +-lim halves
    function automatic fip_t rand_half(input int lim);
        return qtr(2 * (int'($urandom_range(2 * lim)) - lim));
    endfunction

    // flat triangles at z 0, 2 or 4 make equal t likely
    function automatic tri_t rand_tri();
        tri_t tr;
        fip_t zf;
        zf = qtr(8 * int'($urandom_range(2)));
        tr.v0 = '{rand_half(16), rand_half(16), zf};
        tr.v1 = '{rand_half(16), rand_half(16), zf};
        tr.v2 = '{rand_half(16), rand_half(16), zf};
        if ($urandom_range(1) == 0) begin
            tr.v1.z = qtr(2 * int'($urandom_range(16)));
            tr.v2.z = qtr(2 * int'($urandom_range(16)));
        end
        return tr;
    endfunction

    // big close triangle that would win if it got in
    function automatic tri_t near_tri();
        return '{v3(-32, -32, -24), v3(96, -32, -24), v3(-32, 96, -24)};
    endfunction

    task automatic check_fip(input string name, input fip_t exp, input fip_t act);
        if (act !== exp) begin
            $display("Mismatch %s: expected 0x%08h, actual 0x%08h", name, exp, act);
            mismatch_cnt++;
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("Mismatch %s: expected 0x%0h, actual 0x%0h", name, exp, act);
            mismatch_cnt++;
        end
    endtask

    task automatic check_idx(input string name, input tri_idx_t exp, input tri_idx_t act);
        if (act !== exp) begin
            $display("Mismatch %s: expected 0x%08h, actual 0x%08h", name, exp, act);
            mismatch_cnt++;
        end
    endtask

    task automatic begin_batch(input tri_idx_t cnt);
        best         = '{hit: 1'b0, t: FIP_MAX, idx: '0};
        next_idx     = cnt - 1;
        cycle_budget += PIPE_LAT + 10;
        i_tri_cnt    = cnt;
        i_start      = 1'b1;
        @(posedge clk);
        #1;
        i_start = 1'b0;
    endtask

    // counted triangles fold into the expected nearest hit
    task automatic send_tri(input tri_t tr, input int gap, input logic counted);
        isect_t r;
        cycle_budget += gap + 1;
        repeat (gap) begin
            @(posedge clk);
            #1;
        end
        i_tri       = tr;
        i_tri_valid = 1'b1;
        if (counted) begin
            r = ref_intersect(tr, i_ray);
            if (r.hit && (r.t < best.t)) begin
                best = '{hit: 1'b1, t: r.t, idx: next_idx};
            end
            next_idx--;
        end
        @(posedge clk);
        #1;
        i_tri_valid = 1'b0;
    endtask

    task automatic end_batch();
        exp_q.push_back(best);
        while (!o_done) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic one_tri(input ray_t ry, input tri_t tr);
        i_ray = ry;
        begin_batch(1);
        send_tri(tr, 0, 1'b1);
        end_batch();
    endtask

    task automatic print_counts();
        $display("errors: %0d mismatches, %0d other, %0d assertion failures",
                 mismatch_cnt, other_cnt, i_ray_tri_batch.u_chk.fail_cnt);
    endtask

    // compare on each rising o_done at the falling clock edge
    initial begin : compare_proc
        batch_res_t e;
        logic       done_prev;
        done_prev = 1'b1;
        forever begin
            @(negedge clk);
            if (o_done && !done_prev) begin
                if (exp_q.size() == 0) begin
                    $display("o_done rose with no batch pending");
                    other_cnt++;
                end else begin
                    e = exp_q.pop_front();
                    check_bit("o_hit", e.hit, o_hit);
                    check_fip("o_t", e.t, o_t);
                    check_idx("o_tri_index", e.idx, o_tri_index);
                end
            end
            done_prev = o_done;
        end
    end

    initial begin : watchdog
        while (cycle_cnt <= cycle_budget + 50) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout: run did not finish within %0d cycles", cycle_budget + 50);
        print_counts();
        $display("Done: errors found");
        $finish;
    end

    initial begin : main_proc
        tri_idx_t cnt;
        int       gap_max;
        ray_t     ray0;
        void'($urandom(52));
        i_rstn      = 1'b0;
        i_start     = 1'b0;
        i_tri_cnt   = '0;
        i_ray       = '0;
        i_tri       = '0;
        i_tri_valid = 1'b0;
        repeat (8) @(posedge clk);
        #1;
        i_rstn = 1'b1;
        @(negedge clk);
        check_bit("o_done", 1'b1, o_done);
        check_bit("o_hit", 1'b0, o_hit);
        @(posedge clk);
        #1;
        // straight down +z from z = -8
        ray0 = '{v3(0, 0, -32), v3(0, 0, 4)};
        one_tri(ray0, '{v3(-8, -8, 16), v3(16, -8, 16), v3(-8, 16, 16)});
        // outside the edges
        one_tri('{v3(24, 24, -32), v3(0, 0, 4)},
                '{v3(-8, -8, 16), v3(16, -8, 16), v3(-8, 16, 16)});
        // t of 0.25 is under MIN_T
        one_tri(ray0, '{v3(-8, -8, -31), v3(16, -8, -31), v3(-8, 16, -31)});
        // collinear vertices
        one_tri(ray0, '{v3(-8, -8, 16), v3(0, 0, 16), v3(8, 8, 16)});
        // ray parallel to the plane
        one_tri('{v3(0, 0, -32), v3(4, 0, 0)},
                '{v3(-8, -8, 16), v3(16, -8, 16), v3(-8, 16, 16)});
        // empty batch
        begin_batch(0);
        end_batch();
        // every third batch back to back
        for (int b = 0; b < N_RAND; b++) begin
            cnt     = 5 + $urandom_range(7);
            gap_max = (b % 3 == 0) ? 0 : 3;
            i_ray   = '{'{rand_half(4), rand_half(4), qtr(-32)},
                        '{rand_half(1), rand_half(1), FIP_ONE}};
            begin_batch(cnt);
            for (int k = 0; k < cnt; k++) begin
                send_tri(rand_tri(), $urandom_range(gap_max), 1'b1);
            end
            for (int k = 0; k < N_EXTRA; k++) begin
                send_tri(near_tri(), 0, 1'b0);
            end
            end_batch();
            // stray triangle while idle
            send_tri(near_tri(), 0, 1'b0);
        end
        repeat (3) @(posedge clk);
        if (exp_q.size() != 0) begin
            $display("%0d batch results never arrived", exp_q.size());
            other_cnt++;
        end
        print_counts();
        if (mismatch_cnt + other_cnt + i_ray_tri_batch.u_chk.fail_cnt == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// File: tb/ray_tri_batch_chk.sv
// assertion checker for the batch tester top: done level, result hold and issue gating
`timescale 1ns/1ps

module ray_tri_batch_chk (
    input logic             clk,
    input logic             i_rstn,
    input logic             i_start,
    input logic             i_done,
    input logic             i_hit,
    input rt_pkg::fip_t     i_t,
    input rt_pkg::tri_idx_t i_tri_index,
    input logic             i_issue
);

    // failed assertions so far
    int fail_cnt = 0;

    // idle in the first cycle out of reset
    a_done_after_rst: assert property (@(posedge clk) $rose(i_rstn) |-> i_done)
        else begin
            $error("o_done low in the first cycle after reset");
            fail_cnt++;
        end

    // only a start strobe ends the idle level
    a_done_fall: assert property (@(posedge clk) disable iff (!i_rstn)
        $fell(i_done) |-> $past(i_start))
        else begin
            $error("o_done fell without a start in the cycle before");
            fail_cnt++;
        end

    // result held while idle
    a_result_hold: assert property (@(posedge clk) disable iff (!i_rstn)
        (i_done && $past(i_done)) |-> ($stable(i_hit) && $stable(i_t) && $stable(i_tri_index)))
        else begin
            $error("batch result changed while o_done was high");
            fail_cnt++;
        end

    a_no_issue_idle: assert property (@(posedge clk) disable iff (!i_rstn)
        i_done |-> !i_issue)
        else begin
            $error("triangle issued while o_done was high");
            fail_cnt++;
        end

endmodule

bind ray_tri_batch ray_tri_batch_chk u_chk (
    .clk(clk),
    .i_rstn(i_rstn),
    .i_start(i_start),
    .i_done(o_done),
    .i_hit(o_hit),
    .i_t(o_t),
    .i_tri_index(o_tri_index),
    .i_issue(issue)
);

// File: src/ray_tri_batch.sv
// ray-triangle batch tester top: batch controller plus intersection pipeline
`timescale 1ns/1ps

module ray_tri_batch #(
    parameter rt_pkg::fip_t MIN_T = '0
) (
    input  logic             clk,
    input  logic             i_rstn,
    input  logic             i_start,
    input  rt_pkg::tri_idx_t i_tri_cnt,
    input  rt_pkg::ray_t     i_ray,
    input  rt_pkg::tri_t     i_tri,
    input  logic             i_tri_valid,
    output logic             o_hit,
    output rt_pkg::fip_t     o_t,
    output rt_pkg::tri_idx_t o_tri_index,
    output logic             o_done
);
    import rt_pkg::*;

    logic issue;
    logic res_valid;
    logic res_hit;
    fip_t res_t;

    nearest_hit_ctrl u_ctrl (
        .clk(clk),
        .i_rstn(i_rstn),
        .i_start(i_start),
        .i_tri_cnt(i_tri_cnt),
        .i_tri_valid(i_tri_valid),
        .o_issue(issue),
        .i_res_valid(res_valid),
        .i_res_hit(res_hit),
        .i_res_t(res_t),
        .o_hit(o_hit),
        .o_t(o_t),
        .o_tri_index(o_tri_index),
        .o_done(o_done)
    );

    // results return PIPE_LAT cycles after issue
    tri_intersect #(.MIN_T(MIN_T)) u_isect (
        .clk(clk),
        .i_rstn(i_rstn),
        .i_valid(issue),
        .i_tri(i_tri),
        .i_ray(i_ray),
        .o_valid(res_valid),
        .o_hit(res_hit),
        .o_t(res_t)
    );

endmodule

// File: src/nearest_hit_ctrl.sv
// batch controller: counts triangles in and results out, keeps the nearest hit
`timescale 1ns/1ps

module nearest_hit_ctrl (
    input  logic             clk,
    input  logic             i_rstn,
    input  logic             i_start,
    input  rt_pkg::tri_idx_t i_tri_cnt,
    input  logic             i_tri_valid,
    output logic             o_issue,
    input  logic             i_res_valid,
    input  logic             i_res_hit,
    input  rt_pkg::fip_t     i_res_t,
    output logic             o_hit,
    output rt_pkg::fip_t     o_t,
    output rt_pkg::tri_idx_t o_tri_index,
    output logic             o_done
);
    import rt_pkg::*;

    typedef enum logic {
        ST_IDLE,
        ST_RUN
    } state_t;

    state_t   state;
    // triangles still to accept
    tri_idx_t in_rem;
    logic     in_open;
    // results still to come, index counts down with it
    tri_idx_t out_left;
    tri_idx_t res_idx;

    // extra strobes past the count are dropped here
    assign o_issue = i_tri_valid && in_open;
    assign res_idx = out_left - 1'b1;
    assign o_done  = (state == ST_IDLE);

    always_ff @(posedge clk) begin
        if (!i_rstn) begin
            state       <= ST_IDLE;
            in_rem      <= '0;
            in_open     <= 1'b0;
            out_left    <= '0;
            o_hit       <= 1'b0;
            o_t         <= FIP_MAX;
            o_tri_index <= '0;
        end else if (i_start) begin
            state       <= ST_RUN;
            in_rem      <= i_tri_cnt;
            in_open     <= (i_tri_cnt != '0);
            out_left    <= i_tri_cnt;
            o_hit       <= 1'b0;
            o_t         <= FIP_MAX;
            o_tri_index <= '0;
        end else begin
            // input side
            if (o_issue) begin
                in_rem <= in_rem - 1'b1;
                if (in_rem == tri_idx_t'(1)) begin
                    in_open <= 1'b0;
                end
            end
            // output side
            if (state == ST_RUN) begin
                if (out_left == '0) begin
                    // empty batch
                    state <= ST_IDLE;
                end else if (i_res_valid) begin
                    // strict compare, earlier triangle keeps a tie
                    if (i_res_hit && (i_res_t < o_t)) begin
                        o_hit       <= 1'b1;
                        o_t         <= i_res_t;
                        o_tri_index <= res_idx;
                    end
                    out_left <= res_idx;
                    if (res_idx == '0) begin
                        state <= ST_IDLE;
                    end
                end
            end
        end
    end

endmodule

// File: src/tri_intersect.sv
// pipelined ray-triangle intersection: setup, Cramer determinants, divides, hit test
`timescale 1ns/1ps

module tri_intersect #(
    parameter rt_pkg::fip_t MIN_T = '0
) (
    input  logic         clk,
    input  logic         i_rstn,
    input  logic         i_valid,
    input  rt_pkg::tri_t i_tri,
    input  rt_pkg::ray_t i_ray,
    output logic         o_valid,
    output logic         o_hit,
    output rt_pkg::fip_t o_t
);
    import rt_pkg::*;

    vec3_t e;
    vec3_t t1;
    vec3_t t2;
    vec3_t nd;
    fip_t  coef;
    fip_t  det_a;
    fip_t  det_b;
    fip_t  det_t;
    fip_t  coef_d;
    fip_t  a;
    fip_t  b;
    fip_t  t;
    // one bit per stage of latency
    logic [PIPE_LAT-1:0] vld;

    edge_setup u_setup (
        .clk(clk), .i_rstn(i_rstn), .i_tri(i_tri), .i_ray(i_ray),
        .o_e(e), .o_t1(t1), .o_t2(t2), .o_nd(nd)
    );

    // system [t1 t2 -d] * (a b t) = e
    det3_unit u_det_c (.clk(clk), .i_rstn(i_rstn), .i_c0(t1), .i_c1(t2), .i_c2(nd), .o_det(coef));
    det3_unit u_det_a (.clk(clk), .i_rstn(i_rstn), .i_c0(e), .i_c1(t2), .i_c2(nd), .o_det(det_a));
    det3_unit u_det_b (.clk(clk), .i_rstn(i_rstn), .i_c0(t1), .i_c1(e), .i_c2(nd), .o_det(det_b));
    det3_unit u_det_t (.clk(clk), .i_rstn(i_rstn), .i_c0(t1), .i_c1(t2), .i_c2(e), .o_det(det_t));

    fip_div_sat u_div_a (.clk(clk), .i_rstn(i_rstn), .i_x(det_a), .i_y(coef), .o_z(a));
    fip_div_sat u_div_b (.clk(clk), .i_rstn(i_rstn), .i_x(det_b), .i_y(coef), .o_z(b));
    fip_div_sat u_div_t (.clk(clk), .i_rstn(i_rstn), .i_x(det_t), .i_y(coef), .o_z(t));

    // coef rides along with the dividers
    always_ff @(posedge clk) begin
        coef_d <= coef;
    end

    hit_test #(.MIN_T(MIN_T)) u_hit (
        .clk(clk), .i_rstn(i_rstn), .i_coef(coef_d), .i_a(a), .i_b(b), .i_t(t),
        .o_hit(o_hit), .o_t(o_t)
    );

    // valid chain, fixed latency
    always_ff @(posedge clk) begin
        if (!i_rstn) begin
            vld <= '0;
        end else begin
            vld <= {vld[PIPE_LAT-2:0], i_valid};
        end
    end

    assign o_valid = vld[PIPE_LAT-1];

endmodule

// File: src/hit_test.sv
// hit test stage: barycentric and distance conditions, registered hit flag and t
`timescale 1ns/1ps

module hit_test #(
    parameter rt_pkg::fip_t MIN_T = '0
) (
    input  logic         clk,
    input  logic         i_rstn,
    input  rt_pkg::fip_t i_coef,
    input  rt_pkg::fip_t i_a,
    input  rt_pkg::fip_t i_b,
    input  rt_pkg::fip_t i_t,
    output logic         o_hit,
    output rt_pkg::fip_t o_t
);
    import rt_pkg::*;

    // one extra bit catches the carry
    logic signed [32:0] ab_wide;
    fip_t               ab_sum;
    logic               hit_next;

    always_comb begin
        ab_wide = i_a + i_b;
        if (ab_wide > FIP_MAX) begin
            ab_sum = FIP_MAX;
        end else if (ab_wide < FIP_MIN) begin
            ab_sum = FIP_MIN;
        end else begin
            ab_sum = ab_wide[31:0];
        end
        // zero coef means degenerate or parallel, never a hit
        hit_next = (i_coef != '0) && (i_a >= 0) && (i_b >= 0)
                   && (ab_sum <= FIP_ONE) && (i_t >= MIN_T);
    end

    always_ff @(posedge clk) begin
        if (!i_rstn) begin
            o_hit <= 1'b0;
            o_t   <= '0;
        end else begin
            o_hit <= hit_next;
            o_t   <= i_t;
        end
    end

endmodule

// File: src/fip_div_sat.sv
// saturating Q16.16 divider with a one-cycle registered result
`timescale 1ns/1ps

module fip_div_sat (
    input  logic         clk,
    input  logic         i_rstn,
    input  rt_pkg::fip_t i_x,
    input  rt_pkg::fip_t i_y,
    output rt_pkg::fip_t o_z
);
    import rt_pkg::*;

    logic signed [63:0] num;
    logic signed [63:0] den;
    logic signed [63:0] quo;
    fip_t               z_next;

    always_comb begin
        // dividend pre-shifted by the fraction width
        num = $signed({{(32 - FRAC_BITS){i_x[31]}}, i_x, {FRAC_BITS{1'b0}}});
        // dummy divisor when zero, result replaced below
        den = (i_y == '0) ? 64'sd1 : 64'(i_y);
        // truncates toward zero
        quo = num / den;
        if (i_y == '0) begin
            z_next = i_x[31] ? FIP_MIN : FIP_MAX;
        end else if (quo > FIP_MAX) begin
            z_next = FIP_MAX;
        end else if (quo < FIP_MIN) begin
            z_next = FIP_MIN;
        end else begin
            z_next = quo[31:0];
        end
    end

    always_ff @(posedge clk) begin
        if (!i_rstn) begin
            o_z <= '0;
        end else begin
            o_z <= z_next;
        end
    end

endmodule

// File: src/det3_unit.sv
// 3x3 determinant unit: fixed-point cofactor expansion over two register stages
`timescale 1ns/1ps

module det3_unit (
    input  logic          clk,
    input  logic          i_rstn,
    input  rt_pkg::vec3_t i_c0,
    input  rt_pkg::vec3_t i_c1,
    input  rt_pkg::vec3_t i_c2,
    output rt_pkg::fip_t  o_det
);
    import rt_pkg::*;

    // 2x2 minors of the y/z rows
    fip_t m0;
    fip_t m1;
    fip_t m2;
    // x components kept alongside
    fip_t x0;
    fip_t x1;
    fip_t x2;

    // Q16.16 product, full width then rescaled
    function automatic fip_t fmul(input fip_t a, input fip_t b);
        logic signed [63:0] p;
        p = a * b;
        return p[FRAC_BITS +: 32];
    endfunction

    // stage A
    always_ff @(posedge clk) begin
        if (!i_rstn) begin
            m0 <= '0;
            m1 <= '0;
            m2 <= '0;
            x0 <= '0;
            x1 <= '0;
            x2 <= '0;
        end else begin
            m0 <= fmul(i_c1.y, i_c2.z) - fmul(i_c2.y, i_c1.z);
            m1 <= fmul(i_c0.y, i_c2.z) - fmul(i_c2.y, i_c0.z);
            m2 <= fmul(i_c0.y, i_c1.z) - fmul(i_c1.y, i_c0.z);
            x0 <= i_c0.x;
            x1 <= i_c1.x;
            x2 <= i_c2.x;
        end
    end

    // stage B, alternating signs along the x row
    // adds wrap at 32 bits
    always_ff @(posedge clk) begin
        if (!i_rstn) begin
            o_det <= '0;
        end else begin
            o_det <= fmul(x0, m0) - fmul(x1, m1) + fmul(x2, m2);
        end
    end

endmodule

// File: src/edge_setup.sv
// edge setup stage: edge vectors, origin offset and negated direction, registered
`timescale 1ns/1ps

module edge_setup (
    input  logic          clk,
    input  logic          i_rstn,
    input  rt_pkg::tri_t  i_tri,
    input  rt_pkg::ray_t  i_ray,
    output rt_pkg::vec3_t o_e,
    output rt_pkg::vec3_t o_t1,
    output rt_pkg::vec3_t o_t2,
    output rt_pkg::vec3_t o_nd
);
    import rt_pkg::*;

    always_ff @(posedge clk) begin
        if (!i_rstn) begin
            o_e  <= '0;
            o_t1 <= '0;
            o_t2 <= '0;
            o_nd <= '0;
        end else begin
            // origin relative to v0, right-hand side of the system
            o_e.x  <= i_ray.org.x - i_tri.v0.x;
            o_e.y  <= i_ray.org.y - i_tri.v0.y;
            o_e.z  <= i_ray.org.z - i_tri.v0.z;
            // edge v0 -> v1
            o_t1.x <= i_tri.v1.x - i_tri.v0.x;
            o_t1.y <= i_tri.v1.y - i_tri.v0.y;
            o_t1.z <= i_tri.v1.z - i_tri.v0.z;
            // edge v0 -> v2
            o_t2.x <= i_tri.v2.x - i_tri.v0.x;
            o_t2.y <= i_tri.v2.y - i_tri.v0.y;
            o_t2.z <= i_tri.v2.z - i_tri.v0.z;
            // third column is -dir
            o_nd.x <= -i_ray.dir.x;
            o_nd.y <= -i_ray.dir.y;
            o_nd.z <= -i_ray.dir.z;
        end
    end

endmodule

// File: src/rt_pkg.sv
// ray-triangle tester package: Q16.16 types, geometry structs and shared constants
package rt_pkg;

    // fractional bits of the fixed-point format
    localparam int FRAC_BITS = 16;

    // signed Q16.16 value
    typedef logic signed [31:0] fip_t;

    // unsigned triangle count or index
    typedef logic [31:0] tri_idx_t;

    localparam fip_t FIP_ONE = 32'sh0001_0000;
    localparam fip_t FIP_MAX = 32'sh7fff_ffff;
    localparam fip_t FIP_MIN = 32'sh8000_0000;

    // x in the top word, z in the bottom
    typedef struct packed {
        fip_t x;
        fip_t y;
        fip_t z;
    } vec3_t;

    // three vertices, v0 is the reference corner
    typedef struct packed {
        vec3_t v0;
        vec3_t v1;
        vec3_t v2;
    } tri_t;

    // origin and direction, held for a whole batch
    typedef struct packed {
        vec3_t org;
        vec3_t dir;
    } ray_t;

    // determinant latency, minors then products
    localparam int DET_LAT = 2;

    // setup + determinant + divide + hit test
    localparam int PIPE_LAT = DET_LAT + 3;

endpackage
